/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [9:0]  mem_addr_t;

  localparam int MEM_WORDS = 1024;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Encoded as funct3 of the branch
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_t;

  typedef struct packed {
    logic     reg_write;
    logic     load;
    logic     store;
    logic     branch;
    logic     jump;     // jal and jalr
    logic     jalr;
    logic     use_imm;
    logic     pc_src;   // PC as operand a
    alu_op_t  alu_op;
    br_cond_t br_cond;
  } ctrl_t;

  typedef enum logic [2:0] {IF, ID, EX, MEM, WB} stage_t;

  typedef enum logic [1:0] {RESET, WAIT, RUNNING} core_state_t;

  typedef struct packed {
    logic      req;
    logic      we;
    mem_addr_t addr;
    word_t     wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* design/rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t    instr_i,
  output rv_pkg::reg_idx_t rs1_o,
  output rv_pkg::reg_idx_t rs2_o,
  output rv_pkg::reg_idx_t rd_o,
  output rv_pkg::word_t    imm_o,
  output rv_pkg::ctrl_t    ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[30];

  function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  return rv_pkg::ALU_SLL;
      3'b010:  return rv_pkg::ALU_SLT;
      3'b011:  return rv_pkg::ALU_SLTU;
      3'b100:  return rv_pkg::ALU_XOR;
      3'b101:  return sub_sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  return rv_pkg::ALU_OR;
      default: return rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl_o = '0;
    rs1_o  = instr_i[19:15];
    rs2_o  = instr_i[24:20];
    rd_o   = instr_i[11:7];
    imm_o  = {{20{instr_i[31]}}, instr_i[31:20]};  // I format
    case (opcode)
      rv_pkg::OPC_OP: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_op    = alu_sel(funct3, alt);
      end
      rv_pkg::OPC_OPIMM: begin
        rs2_o            = '0;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.alu_op    = alu_sel(funct3, funct3 == 3'b101 && alt);  // Only srai has alt
      end
      rv_pkg::OPC_LOAD: begin
        rs2_o            = '0;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.load      = 1'b1;
        ctrl_o.use_imm   = 1'b1;
      end
      rv_pkg::OPC_STORE: begin
        rd_o           = '0;
        imm_o          = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        ctrl_o.store   = 1'b1;
        ctrl_o.use_imm = 1'b1;
      end
      rv_pkg::OPC_BRANCH: begin
        rd_o           = '0;
        imm_o          = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                          instr_i[11:8], 1'b0};
        ctrl_o.branch  = 1'b1;
        ctrl_o.br_cond = rv_pkg::br_cond_t'(funct3);
      end
      rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
        rs1_o            = '0;  // x0 supplies the zero for lui
        rs2_o            = '0;
        imm_o            = {instr_i[31:12], 12'b0};
        ctrl_o.reg_write = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.pc_src    = opcode == rv_pkg::OPC_AUIPC;
      end
      rv_pkg::OPC_JAL: begin
        rs1_o            = '0;
        rs2_o            = '0;
        imm_o            = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 1'b1;
        ctrl_o.pc_src    = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        rs2_o            = '0;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 1'b1;
        ctrl_o.jalr      = 1'b1;
        ctrl_o.pc_src    = 1'b1;  // Link is pc+4, target from rs1
        ctrl_o.use_imm   = 1'b1;
      end
      default: begin
        rs1_o = '0;
        rs2_o = '0;
        rd_o  = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t waddr_i,
  input  rv_pkg::word_t    wdata_i,
  input  rv_pkg::reg_idx_t raddr1_i,
  input  rv_pkg::reg_idx_t raddr2_i,
  output rv_pkg::word_t    rdata1_o,
  output rv_pkg::word_t    rdata2_o
);

  rv_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0) regs[waddr_i] <= wdata_i;
  end

  // Write-through so WB and ID can overlap
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

  // Stored word reads back next cycle unless a newer write bypasses it
  a_write_readback: assert property (@(posedge clk) disable iff (rst)
    we_i && waddr_i != '0 |=>
      we_i || raddr1_i != $past(waddr_i) || rdata1_o == $past(wdata_i));

endmodule

`default_nettype wire

/* design/rv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t  op_i,
  input  rv_pkg::word_t    a_i,
  input  rv_pkg::word_t    b_i,
  input  rv_pkg::br_cond_t cond_i,
  output rv_pkg::word_t    result_o,
  output logic             taken_o
);

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv_pkg::ALU_AND:  result_o = a_i & b_i;
      rv_pkg::ALU_OR:   result_o = a_i | b_i;
      rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv_pkg::ALU_SLL:  result_o = a_i << b_i[4:0];
      rv_pkg::ALU_SRL:  result_o = a_i >> b_i[4:0];
      rv_pkg::ALU_SRA:  result_o = rv_pkg::word_t'($signed(a_i) >>> b_i[4:0]);
      rv_pkg::ALU_SLT:  result_o = rv_pkg::word_t'($signed(a_i) < $signed(b_i));
      rv_pkg::ALU_SLTU: result_o = rv_pkg::word_t'(a_i < b_i);
      default:          result_o = '0;
    endcase
  end

  always_comb begin
    case (cond_i)
      rv_pkg::BR_EQ:  taken_o = a_i == b_i;
      rv_pkg::BR_NE:  taken_o = a_i != b_i;
      rv_pkg::BR_LT:  taken_o = $signed(a_i) < $signed(b_i);
      rv_pkg::BR_GE:  taken_o = $signed(a_i) >= $signed(b_i);
      rv_pkg::BR_LTU: taken_o = a_i < b_i;
      rv_pkg::BR_GEU: taken_o = a_i >= b_i;
      default:        taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/rv_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_pipeline (
  input  logic             clk,
  input  logic             rst,
  input  logic             run_i,
  output rv_pkg::mem_req_t fetch_req_o,
  input  logic             fetch_ready_i,
  output rv_pkg::mem_req_t data_req_o,
  input  logic             data_ready_i,
  input  rv_pkg::word_t    rdata_i,
  output logic             wb_valid_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::word_t    wb_data_o
);

  typedef struct packed {
    logic          valid;
    rv_pkg::word_t pc;
    rv_pkg::word_t instr;
  } id_reg_t;

  typedef struct packed {
    logic             valid;
    rv_pkg::word_t    pc;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    a;
    rv_pkg::word_t    b;
  } ex_reg_t;

  typedef struct packed {
    logic             valid;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    result;
    rv_pkg::word_t    sdata;
  } mem_reg_t;

  typedef struct packed {
    logic             valid;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    data;
  } wb_reg_t;

  rv_pkg::core_state_t state_q;
  rv_pkg::word_t       pc_q;
  rv_pkg::word_t       buf_q;
  logic                buf_valid_q;
  logic                drop_q;
  id_reg_t             id_q;
  ex_reg_t             ex_q;
  mem_reg_t            mem_q;
  wb_reg_t             wb_q;

  logic [4:0]       stall;
  logic [4:0]       flush;
  logic             mem_wait;
  logic             load_use;
  logic             redirect;
  logic             if_have;
  rv_pkg::word_t    if_word;
  rv_pkg::reg_idx_t id_rs1;
  rv_pkg::reg_idx_t id_rs2;
  rv_pkg::reg_idx_t id_rd;
  rv_pkg::word_t    id_imm;
  rv_pkg::ctrl_t    id_ctrl;
  rv_pkg::word_t    id_a;
  rv_pkg::word_t    id_b;
  rv_pkg::word_t    fwd_a;
  rv_pkg::word_t    fwd_b;
  rv_pkg::word_t    op_a;
  rv_pkg::word_t    op_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    tgt_sum;
  logic             taken;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= rv_pkg::RESET;
    end else begin
      case (state_q)
        rv_pkg::RESET:   if (run_i) state_q <= rv_pkg::WAIT;
        rv_pkg::WAIT:    state_q <= rv_pkg::RUNNING;
        rv_pkg::RUNNING: state_q <= rv_pkg::RUNNING;
        default:         state_q <= rv_pkg::RESET;
      endcase
    end
  end

  assign mem_wait = mem_q.valid && (mem_q.ctrl.load || mem_q.ctrl.store) && !data_ready_i;
  assign load_use = ex_q.valid && ex_q.ctrl.load && ex_q.rd != '0 && id_q.valid &&
                    (ex_q.rd == id_rs1 || ex_q.rd == id_rs2);
  assign redirect = ex_q.valid && !mem_wait && (ex_q.ctrl.jump || (ex_q.ctrl.branch && taken));

  always_comb begin
    stall = '0;
    flush = '0;
    stall[rv_pkg::IF]  = mem_wait || load_use;
    stall[rv_pkg::ID]  = mem_wait || load_use;
    stall[rv_pkg::EX]  = mem_wait;
    stall[rv_pkg::MEM] = mem_wait;
    flush[rv_pkg::IF]  = redirect;
    flush[rv_pkg::ID]  = redirect;
  end

  // Word from this cycle's fetch_ready, or one parked while ID was stalled
  assign if_have = buf_valid_q || (fetch_ready_i && !drop_q);
  assign if_word = buf_valid_q ? buf_q : rdata_i;
  assign fetch_req_o = '{req: state_q == rv_pkg::RUNNING && !buf_valid_q && !drop_q,
                         we: 1'b0, addr: pc_q[11:2], wdata: '0};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q        <= '0;
      buf_valid_q <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      drop_q <= flush[rv_pkg::IF];  // Swallows a ready from before the redirect
      if (flush[rv_pkg::IF]) begin
        pc_q        <= {tgt_sum[31:1], 1'b0};
        buf_valid_q <= 1'b0;
      end else if (if_have && !stall[rv_pkg::IF]) begin
        pc_q        <= pc_q + 32'd4;
        buf_valid_q <= 1'b0;
      end else if (fetch_ready_i && !drop_q) begin
        buf_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_ready_i && !drop_q) buf_q <= rdata_i;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      id_q <= '0;
    end else if (flush[rv_pkg::ID]) begin
      id_q <= '0;
    end else if (!stall[rv_pkg::ID]) begin
      id_q <= '{valid: if_have && !flush[rv_pkg::IF], pc: pc_q, instr: if_word};
    end
  end

  rv_decoder i_rv_decoder (
    .instr_i (id_q.instr),
    .rs1_o   (id_rs1),
    .rs2_o   (id_rs2),
    .rd_o    (id_rd),
    .imm_o   (id_imm),
    .ctrl_o  (id_ctrl)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .we_i     (wb_q.valid),
    .waddr_i  (wb_q.rd),
    .wdata_i  (wb_q.data),
    .raddr1_i (id_rs1),
    .raddr2_i (id_rs2),
    .rdata1_o (id_a),
    .rdata2_o (id_b)
  );

  function automatic rv_pkg::word_t fwd(input rv_pkg::reg_idx_t rs, input rv_pkg::word_t rf,
                                        input mem_reg_t m, input wb_reg_t w);
    if (rs != '0 && m.valid && m.ctrl.reg_write && !m.ctrl.load && m.rd == rs) return m.result;
    if (w.valid && w.rd == rs) return w.data;
    return rf;
  endfunction

  assign fwd_a = fwd(ex_q.rs1, ex_q.a, mem_q, wb_q);
  assign fwd_b = fwd(ex_q.rs2, ex_q.b, mem_q, wb_q);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ex_q <= '0;
    end else if (flush[rv_pkg::EX]) begin
      ex_q <= '0;
    end else if (!stall[rv_pkg::EX]) begin
      if (stall[rv_pkg::ID] || flush[rv_pkg::ID]) begin
        ex_q <= '0;  // Bubble
      end else begin
        ex_q <= '{valid: id_q.valid, pc: id_q.pc, ctrl: id_ctrl, rs1: id_rs1, rs2: id_rs2,
                  rd: id_rd, imm: id_imm, a: id_a, b: id_b};
      end
    end else begin
      ex_q.a <= fwd_a;  // Producer may leave WB while EX waits
      ex_q.b <= fwd_b;
    end
  end

  assign op_a    = ex_q.ctrl.pc_src ? ex_q.pc : fwd_a;
  assign op_b    = ex_q.ctrl.jump ? 32'd4 : (ex_q.ctrl.use_imm ? ex_q.imm : fwd_b);
  assign tgt_sum = (ex_q.ctrl.jalr ? fwd_a : ex_q.pc) + ex_q.imm;

  rv_alu i_rv_alu (
    .op_i     (ex_q.ctrl.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .cond_i   (ex_q.ctrl.br_cond),
    .result_o (alu_result),
    .taken_o  (taken)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_q <= '0;
    end else if (flush[rv_pkg::MEM]) begin
      mem_q <= '0;
    end else if (!stall[rv_pkg::MEM]) begin
      mem_q <= '{valid: ex_q.valid && !stall[rv_pkg::EX] && !flush[rv_pkg::EX],
                 ctrl: ex_q.ctrl, rd: ex_q.rd, result: alu_result, sdata: fwd_b};
    end
  end

  assign data_req_o = '{req: mem_q.valid && (mem_q.ctrl.load || mem_q.ctrl.store),
                        we: mem_q.ctrl.store, addr: mem_q.result[11:2], wdata: mem_q.sdata};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wb_q <= '0;
    end else if (flush[rv_pkg::WB]) begin
      wb_q <= '0;
    end else if (!stall[rv_pkg::WB]) begin
      wb_q <= '{valid: mem_q.valid && !stall[rv_pkg::MEM] && mem_q.ctrl.reg_write &&
                       mem_q.rd != '0,
                rd: mem_q.rd, data: mem_q.ctrl.load ? rdata_i : mem_q.result};
    end
  end

  assign wb_valid_o = wb_q.valid;
  assign wb_rd_o    = wb_q.rd;
  assign wb_data_o  = wb_q.data;

  a_data_req_held: assert property (@(posedge clk) disable iff (rst)
    data_req_o.req && !data_ready_i |=> data_req_o.req);

  a_no_flush_on_hold: assert property (@(posedge clk) disable iff (rst)
    (flush & stall) == '0);

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::mem_req_t load_req_i,
  input  rv_pkg::mem_req_t data_req_i,
  input  rv_pkg::mem_req_t fetch_req_i,
  output logic             load_ready_o,
  output logic             data_ready_o,
  output logic             fetch_ready_o,
  output rv_pkg::mem_req_t mem_req_o
);

  logic load_win;
  logic data_win;
  logic fetch_win;

  // A peer whose ready pulses now is still holding the finished request
  assign load_win  = load_req_i.req && !load_ready_o;
  assign data_win  = data_req_i.req && !data_ready_o && !load_win;
  assign fetch_win = fetch_req_i.req && !fetch_ready_o && !load_win && !data_win;

  always_comb begin
    if (load_win)       mem_req_o = load_req_i;
    else if (data_win)  mem_req_o = data_req_i;
    else if (fetch_win) mem_req_o = fetch_req_i;
    else                mem_req_o = '0;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      load_ready_o  <= 1'b0;
      data_ready_o  <= 1'b0;
      fetch_ready_o <= 1'b0;
    end else begin
      load_ready_o  <= load_win;
      data_ready_o  <= data_win;
      fetch_ready_o <= fetch_win;
    end
  end

  // Data peer keeps its request up through its ready
  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    $onehot0({load_ready_o, data_ready_o, fetch_ready_o}) &&
    (!data_ready_o || data_req_i.req));

endmodule

`default_nettype wire

/* design/word_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module word_mem (
  input  logic             clk,
  input  rv_pkg::mem_req_t req_i,
  output rv_pkg::word_t    rdata_o
);

  rv_pkg::word_t mem [0:rv_pkg::MEM_WORDS-1];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (req_i.req) begin
      if (req_i.we) mem[req_i.addr] <= req_i.wdata;
      rdata_o <= mem[req_i.addr];
    end
  end

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              run_i,
  input  logic              load_we_i,
  input  rv_pkg::mem_addr_t load_addr_i,
  input  rv_pkg::word_t     load_data_i,
  output logic              load_ready_o,
  output logic              wb_valid_o,
  output rv_pkg::reg_idx_t  wb_rd_o,
  output rv_pkg::word_t     wb_data_o
);

  rv_pkg::mem_req_t load_req;
  rv_pkg::mem_req_t data_req;
  rv_pkg::mem_req_t fetch_req;
  rv_pkg::mem_req_t mem_req;
  logic             data_ready;
  logic             fetch_ready;
  rv_pkg::word_t    rdata;

  assign load_req = '{req: load_we_i, we: load_we_i, addr: load_addr_i, wdata: load_data_i};

  rv_pipeline i_rv_pipeline (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .fetch_req_o   (fetch_req),
    .fetch_ready_i (fetch_ready),
    .data_req_o    (data_req),
    .data_ready_i  (data_ready),
    .rdata_i       (rdata),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  mem_arbiter i_mem_arbiter (
    .clk           (clk),
    .rst           (rst),
    .load_req_i    (load_req),
    .data_req_i    (data_req),
    .fetch_req_i   (fetch_req),
    .load_ready_o  (load_ready_o),
    .data_ready_o  (data_ready),
    .fetch_ready_o (fetch_ready),
    .mem_req_o     (mem_req)
  );

  word_mem i_word_mem (
    .clk     (clk),
    .req_i   (mem_req),
    .rdata_o (rdata)
  );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* dv/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

  typedef struct packed {
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    data;
  } wb_entry_t;

  localparam int DATA_BASE        = 512;  // Word address of the data region
  localparam int DATA_WORDS       = 16;
  localparam int CYCLES_PER_INSTR = 200;
  localparam int QUIET_CYCLES     = 50;

  logic              clk;
  logic              rst;
  logic              run;
  logic              load_we;
  rv_pkg::mem_addr_t load_addr;
  rv_pkg::word_t     load_data;
  logic              load_ready;
  logic              wb_valid;
  rv_pkg::reg_idx_t  wb_rd;
  rv_pkg::word_t     wb_data;

  logic [31:0]      seed = 32'h0011c034;
  rv_pkg::word_t    prog [$];
  wb_entry_t        exp_q [$];
  rv_pkg::reg_idx_t last_rd = '0;
  int               instr_total = 0;
  int               error_count = 0;
  int               wb_seen = 0;
  int               br_count = 0;
  logic             checking = 1'b0;

  tb_clock i_tb_clock (.clk_o(clk));

  rv_core_top i_rv_core_top (
    .clk          (clk),
    .rst          (rst),
    .run_i        (run),
    .load_we_i    (load_we),
    .load_addr_i  (load_addr),
    .load_data_i  (load_data),
    .load_ready_o (load_ready),
    .wb_valid_o   (wb_valid),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  function automatic rv_pkg::word_t fill_word(input rv_pkg::mem_addr_t addr);
    return {addr, 22'h0} ^ ({22'h0, addr} * 32'h00010f35) ^ 32'ha5a50000;
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [2:0] f3, input logic alt,
                                          input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic rv_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_s(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
  endfunction

  function automatic logic [4:0] pick_dest();
    return (rand_below(8) == 0) ? 5'd0 : 5'(1 + rand_below(31));
  endfunction

  // Half of the sources reuse the last result
  function automatic logic [4:0] pick_src();
    if (rand_below(2) == 0) return last_rd;
    return 5'(rand_below(32));
  endfunction

  function automatic void gen_alu();
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    f3  = 3'(rand_below(8));
    rd  = pick_dest();
    rs1 = pick_src();
    rs2 = pick_src();
    prog.push_back(enc_r(f3, (f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1,
                         rd, rs1, rs2));
    last_rd = rd;
  endfunction

  function automatic void gen_imm();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] imm;
    rd  = pick_dest();
    imm = 12'(next_rand());
    case (rand_below(4))
      0: prog.push_back(enc_u(rv_pkg::OPC_LUI, rd, 20'(next_rand())));
      1: prog.push_back(enc_u(rv_pkg::OPC_AUIPC, rd, 20'(next_rand())));
      default: begin
        f3  = 3'(rand_below(8));
        rs1 = pick_src();
        if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
        else if (f3 == 3'b101) imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli or srai
        prog.push_back(enc_i(rv_pkg::OPC_OPIMM, f3, rd, rs1, imm));
      end
    endcase
    last_rd = rd;
  endfunction

  // Base x0 with a negative offset lands in the data region
  function automatic void gen_mem();
    logic [11:0] off;
    logic [4:0]  rd;
    logic [4:0]  dest;
    logic [4:0]  src;
    off = 12'(-2048 + 4 * rand_below(DATA_WORDS));
    rd  = 5'(1 + rand_below(31));
    src = pick_src();
    if (rand_below(2) == 0) prog.push_back(enc_s(src, 5'd0, off));
    prog.push_back(enc_i(rv_pkg::OPC_LOAD, 3'b010, rd, 5'd0, off));
    dest = pick_dest();
    src  = pick_src();
    prog.push_back(enc_r(3'b000, 1'b0, dest, rd, src));  // Uses the load at once
    last_rd = dest;
  endfunction

  function automatic void gen_ctrl();
    logic [2:0] conds [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    int         skip;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    skip = 1 + rand_below(3);
    rd   = pick_dest();
    case (rand_below(4))
      0: prog.push_back(enc_j(rd, 21'(4 * (skip + 1))));
      1: begin
        rs1 = 5'(1 + rand_below(31));
        prog.push_back(enc_u(rv_pkg::OPC_AUIPC, rs1, 20'd0));
        prog.push_back(enc_i(rv_pkg::OPC_JALR, 3'b000, rd, rs1, 12'(4 * (skip + 2))));
      end
      default: begin
        rs1 = pick_src();
        rs2 = ((br_count / 6) % 2 == 1) ? rs1 : pick_src();
        prog.push_back(enc_b(conds[br_count % 6], rs1, rs2, 13'(4 * (skip + 1))));
        br_count++;
      end
    endcase
    repeat (skip) begin
      if (rand_below(2) == 0) gen_alu();
      else gen_imm();
    end
  endfunction

  function automatic void build_program(input int kind, input int body_len);
    int k;
    prog.delete();
    for (int r = 1; r < 32; r++) begin
      prog.push_back(enc_i(rv_pkg::OPC_OPIMM, 3'b000, 5'(r), 5'd0, 12'(next_rand())));
    end
    last_rd = 5'd31;
    while (prog.size() < 31 + body_len) begin
      k = (kind == 4) ? rand_below(4) : kind;
      case (k)
        0:       gen_alu();
        1:       gen_imm();
        2:       gen_mem();
        default: gen_ctrl();
      endcase
    end
    prog.push_back(enc_j(5'd0, 21'd0));  // Spin here
    instr_total += prog.size();
  endfunction

  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rv_pkg::word_t a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Architectural model, fills the expected writeback queue in program order
  function automatic void run_model();
    rv_pkg::word_t mem [rv_pkg::MEM_WORDS];
    rv_pkg::word_t x [32];
    rv_pkg::word_t pc;
    rv_pkg::word_t npc;
    rv_pkg::word_t ins;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t ea;
    rv_pkg::word_t res;
    logic          wr;
    int            steps;
    for (int i = 0; i < rv_pkg::MEM_WORDS; i++) begin
      mem[i] = (i < prog.size()) ? prog[i] : fill_word(10'(i));
    end
    for (int i = 0; i < 32; i++) x[i] = '0;
    exp_q.delete();
    pc    = '0;
    steps = 0;
    while (steps < 20000) begin
      ins = mem[pc[11:2]];
      if (ins == enc_j(5'd0, 21'd0)) break;
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      npc   = pc + 32'd4;
      res   = '0;
      wr    = 1'b1;
      case (ins[6:0])
        rv_pkg::OPC_OP:    res = alu_ref(ins[14:12], ins[30], a, b);
        rv_pkg::OPC_OPIMM: res = alu_ref(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
        rv_pkg::OPC_LUI:   res = {ins[31:12], 12'b0};
        rv_pkg::OPC_AUIPC: res = pc + {ins[31:12], 12'b0};
        rv_pkg::OPC_LOAD: begin
          ea  = a + imm_i;
          res = mem[ea[11:2]];
        end
        rv_pkg::OPC_STORE: begin
          wr = 1'b0;
          ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mem[ea[11:2]] = b;
        end
        rv_pkg::OPC_BRANCH: begin
          wr = 1'b0;
          if (branch_ref(ins[14:12], a, b)) begin
            npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        rv_pkg::OPC_JAL: begin
          res = pc + 32'd4;
          npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        rv_pkg::OPC_JALR: begin
          res = pc + 32'd4;
          npc = (a + imm_i) & ~32'd1;
        end
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        x[ins[11:7]] = res;
        exp_q.push_back('{rd: ins[11:7], data: res});
      end
      pc = npc;
      steps++;
    end
  endfunction

  task automatic check_value(input string what, input rv_pkg::word_t got,
                             input rv_pkg::word_t exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  // Loader holds its request until load_ready
  task automatic load_word(input rv_pkg::mem_addr_t addr, input rv_pkg::word_t data);
    int waits;
    @(negedge clk);
    check_value("load_ready before request", 32'(load_ready), 32'd0);
    load_we   = 1'b1;
    load_addr = addr;
    load_data = data;
    waits     = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!load_ready);
    check_value("load_ready latency", 32'(waits), 32'd1);  // Loader has top priority
    load_we = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) load_word(10'(i), prog[i]);
    for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
      load_word(10'(i), fill_word(10'(i)));
    end
  endtask

  task automatic run_test(input int num, input string name, input int kind, input int body_len);
    int errors_before;
    int seen_before;
    build_program(kind, body_len);
    run_model();
    errors_before = error_count;
    seen_before   = wb_seen;
    run = 1'b0;
    apply_reset();  // Stops the previous program before its memory is overwritten
    load_program();
    apply_reset();
    checking = 1'b1;
    @(negedge clk);
    run = 1'b1;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (QUIET_CYCLES) @(posedge clk);
    checking = 1'b0;
    $display("Test %0d (%s): %0d writebacks, %0d errors", num, name,
             wb_seen - seen_before, error_count - errors_before);
  endtask

  always @(negedge clk) begin : compare
    wb_entry_t exp_wb;
    if (checking && wb_valid) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Extra writeback of x%0d = %h at %0t ns after the last expected result",
                 wb_rd, wb_data, $time);
      end else begin
        exp_wb = exp_q.pop_front();
        check_value("writeback rd", 32'(wb_rd), 32'(exp_wb.rd));
        check_value("writeback data", wb_data, exp_wb.data);
        wb_seen++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= CYCLES_PER_INSTR * instr_total) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the core stopped retiring the expected results",
             cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    run_test(1, "register ALU chains", 0, 40);
    run_test(2, "immediates, lui, auipc", 1, 40);
    run_test(3, "stores, loads, load-use", 2, 40);
    run_test(4, "branches and jumps", 3, 60);
    run_test(5, "random mix", 4, 200);
    $display("Done: %0d writebacks checked, %0d errors", wb_seen, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core_top.f */
rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pipeline.sv
design/mem_arbiter.sv
design/word_mem.sv
design/rv_core_top.sv
dv/tb_clock.sv
dv/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || echo '*** TEST FAILED ***' >> $(LOG)
	cat $(LOG)
	! grep -qF '*** TEST FAILED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
